//--- lcd_video_pkg.sv
package lcd_video_pkg;

   // Framebuffer geometry, 64 x 32 tile
   localparam int FB_X_BITS = 6;
   localparam int FB_Y_BITS = 5;

   // Widths with a meaning
   typedef logic [9:0]                     coord_x_t;
   typedef logic [8:0]                     coord_y_t;
   typedef logic [7:0]                     porch_t;
   typedef logic [7:0]                     clk_div_t;
   typedef logic [FB_X_BITS+FB_Y_BITS-1:0] fb_addr_t;
   typedef logic [7:0]                     axil_addr_t;
   typedef logic [31:0]                    axil_data_t;

   // Register byte offsets
   localparam axil_addr_t REG_CTRL     = 8'h00;
   localparam axil_addr_t REG_CLK_DIV  = 8'h04;
   localparam axil_addr_t REG_H_ACTIVE = 8'h08;
   localparam axil_addr_t REG_H_PORCH  = 8'h0C;
   localparam axil_addr_t REG_V_ACTIVE = 8'h10;
   localparam axil_addr_t REG_V_PORCH  = 8'h14;

   // Smallest divisor that still gives a clock with two phases
   localparam clk_div_t MIN_CLK_DIV = 8'd2;

   localparam logic [1:0] RESP_OKAY   = 2'd0;
   localparam logic [1:0] RESP_SLVERR = 2'd2;

   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } rgb_t;

   typedef struct packed {
      logic     enable;
      logic     backlight;
      clk_div_t clk_div;
      coord_x_t h_active;
      porch_t   h_front;
      porch_t   h_sync;
      porch_t   h_back;
      coord_y_t v_active;
      porch_t   v_front;
      porch_t   v_sync;
      porch_t   v_back;
   } lcd_cfg_t;

   // 480x272 panel, off and dark out of reset
   localparam lcd_cfg_t CFG_RESET = '{
      enable: 1'b0, backlight: 1'b0, clk_div: 8'd5,
      h_active: 10'd480, h_front: 8'd2, h_sync: 8'd41, h_back: 8'd2,
      v_active: 9'd272, v_front: 8'd2, v_sync: 8'd10, v_back: 8'd2
   };

   typedef struct packed {
      logic       aw_valid;
      axil_addr_t aw_addr;
      logic       w_valid;
      axil_data_t w_data;
      logic [3:0] w_strb;
      logic       b_ready;
      logic       ar_valid;
      axil_addr_t ar_addr;
      logic       r_ready;
   } axil_req_t;

   typedef struct packed {
      logic       aw_ready;
      logic       w_ready;
      logic       b_valid;
      logic [1:0] b_resp;
      logic       ar_ready;
      logic       r_valid;
      axil_data_t r_data;
      logic [1:0] r_resp;
   } axil_rsp_t;

   typedef struct packed {
      logic     enable;
      fb_addr_t address;
      rgb_t     data;
   } fb_write_t;

   // Syncs active high inside the design
   typedef struct packed {
      logic     hsync;
      logic     vsync;
      logic     de;
      coord_x_t x;
      coord_y_t y;
   } timing_beat_t;

   typedef struct packed {
      logic hsync;
      logic vsync;
      logic de;
      rgb_t rgb;
   } pixel_beat_t;

endpackage

//--- lcd_csr_axil.sv
`timescale 1ns/1ps

module lcd_csr_axil (
   input  logic                     clk,
   input  logic                     arst_n,
   input  lcd_video_pkg::axil_req_t axil_req,
   output lcd_video_pkg::axil_rsp_t axil_rsp,
   output lcd_video_pkg::lcd_cfg_t  cfg
);

   // Register image as seen on the bus
   function automatic lcd_video_pkg::axil_data_t reg_read(
      input lcd_video_pkg::lcd_cfg_t   c,
      input lcd_video_pkg::axil_addr_t addr
   );
      case (addr)
         lcd_video_pkg::REG_CTRL:     reg_read = {30'd0, c.backlight, c.enable};
         lcd_video_pkg::REG_CLK_DIV:  reg_read = {24'd0, c.clk_div};
         lcd_video_pkg::REG_H_ACTIVE: reg_read = {22'd0, c.h_active};
         lcd_video_pkg::REG_H_PORCH:  reg_read = {8'd0, c.h_back, c.h_sync, c.h_front};
         lcd_video_pkg::REG_V_ACTIVE: reg_read = {23'd0, c.v_active};
         lcd_video_pkg::REG_V_PORCH:  reg_read = {8'd0, c.v_back, c.v_sync, c.v_front};
         default:                     reg_read = '0;
      endcase
   endfunction

   function automatic logic reg_hit(input lcd_video_pkg::axil_addr_t addr);
      return addr inside {lcd_video_pkg::REG_CTRL, lcd_video_pkg::REG_CLK_DIV,
                          lcd_video_pkg::REG_H_ACTIVE, lcd_video_pkg::REG_H_PORCH,
                          lcd_video_pkg::REG_V_ACTIVE, lcd_video_pkg::REG_V_PORCH};
   endfunction

   logic                       wr_fire;
   logic                       rd_fire;
   lcd_video_pkg::axil_data_t  wr_old;
   lcd_video_pkg::axil_data_t  wr_merged;
   lcd_video_pkg::clk_div_t    div_new;
   logic                       b_valid_q;
   logic [1:0]                 b_resp_q;
   logic                       r_valid_q;
   logic [1:0]                 r_resp_q;
   lcd_video_pkg::axil_data_t  r_data_q;

   // Address and data taken together, one write in flight
   assign wr_fire = axil_req.aw_valid & axil_req.w_valid & ~b_valid_q;
   assign rd_fire = axil_req.ar_valid & ~r_valid_q;

   // Byte merge against current contents
   always_comb begin
      wr_old = reg_read(cfg, axil_req.aw_addr);
      for (int b = 0; b < 4; b++) begin
         wr_merged[8*b +: 8] = axil_req.w_strb[b] ? axil_req.w_data[8*b +: 8]
                                                  : wr_old[8*b +: 8];
      end
      // Divisor clamped at the bottom
      if (wr_merged[7:0] < lcd_video_pkg::MIN_CLK_DIV) begin
         div_new = lcd_video_pkg::MIN_CLK_DIV;
      end else begin
         div_new = wr_merged[7:0];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cfg <= lcd_video_pkg::CFG_RESET;
      end else if (wr_fire) begin
         case (axil_req.aw_addr)
            lcd_video_pkg::REG_CTRL: begin
               cfg.enable    <= wr_merged[0];
               cfg.backlight <= wr_merged[1];
            end
            lcd_video_pkg::REG_CLK_DIV:  cfg.clk_div  <= div_new;
            lcd_video_pkg::REG_H_ACTIVE: cfg.h_active <= wr_merged[9:0];
            lcd_video_pkg::REG_H_PORCH: begin
               cfg.h_front <= wr_merged[7:0];
               cfg.h_sync  <= wr_merged[15:8];
               cfg.h_back  <= wr_merged[23:16];
            end
            lcd_video_pkg::REG_V_ACTIVE: cfg.v_active <= wr_merged[8:0];
            lcd_video_pkg::REG_V_PORCH: begin
               cfg.v_front <= wr_merged[7:0];
               cfg.v_sync  <= wr_merged[15:8];
               cfg.v_back  <= wr_merged[23:16];
            end
            // Unmapped, nothing stored
            default: ;
         endcase
      end
   end

   // Response channels, held until the host takes them
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         b_valid_q <= 1'b0;
         b_resp_q  <= lcd_video_pkg::RESP_OKAY;
         r_valid_q <= 1'b0;
         r_resp_q  <= lcd_video_pkg::RESP_OKAY;
      end else begin
         if (wr_fire) begin
            b_valid_q <= 1'b1;
            b_resp_q  <= reg_hit(axil_req.aw_addr) ? lcd_video_pkg::RESP_OKAY
                                                   : lcd_video_pkg::RESP_SLVERR;
         end else if (axil_req.b_ready) begin
            b_valid_q <= 1'b0;
         end
         if (rd_fire) begin
            r_valid_q <= 1'b1;
            r_resp_q  <= reg_hit(axil_req.ar_addr) ? lcd_video_pkg::RESP_OKAY
                                                   : lcd_video_pkg::RESP_SLVERR;
         end else if (axil_req.r_ready) begin
            r_valid_q <= 1'b0;
         end
      end
   end

   // Read data captured with the address
   always_ff @(posedge clk) begin
      if (rd_fire) begin
         r_data_q <= reg_read(cfg, axil_req.ar_addr);
      end
   end

   always_comb begin
      axil_rsp.aw_ready = wr_fire;
      axil_rsp.w_ready  = wr_fire;
      axil_rsp.b_valid  = b_valid_q;
      axil_rsp.b_resp   = b_resp_q;
      axil_rsp.ar_ready = ~r_valid_q;
      axil_rsp.r_valid  = r_valid_q;
      axil_rsp.r_data   = r_data_q;
      axil_rsp.r_resp   = r_resp_q;
   end

endmodule

//--- lcd_timing.sv
`timescale 1ns/1ps

module lcd_timing (
   input  logic                        clk,
   input  logic                        arst_n,
   input  lcd_video_pkg::lcd_cfg_t     cfg,
   output logic                        pixel_strobe,
   output lcd_video_pkg::timing_beat_t beat
);

   lcd_video_pkg::clk_div_t div_cnt;
   lcd_video_pkg::coord_x_t h_cnt;
   lcd_video_pkg::coord_x_t h_sync_start;
   lcd_video_pkg::coord_x_t h_sync_end;
   lcd_video_pkg::coord_x_t h_last;
   lcd_video_pkg::coord_y_t v_cnt;
   lcd_video_pkg::coord_y_t v_sync_start;
   lcd_video_pkg::coord_y_t v_sync_end;
   lcd_video_pkg::coord_y_t v_last;
   logic                    tick;
   logic                    hsync;
   logic                    vsync;
   logic                    de;

   // Region boundaries in the order active, front, sync, back
   always_comb begin
      h_sync_start = cfg.h_active + lcd_video_pkg::coord_x_t'(cfg.h_front);
      h_sync_end   = h_sync_start + lcd_video_pkg::coord_x_t'(cfg.h_sync);
      h_last       = h_sync_end + lcd_video_pkg::coord_x_t'(cfg.h_back) - 10'd1;
      v_sync_start = cfg.v_active + lcd_video_pkg::coord_y_t'(cfg.v_front);
      v_sync_end   = v_sync_start + lcd_video_pkg::coord_y_t'(cfg.v_sync);
      v_last       = v_sync_end + lcd_video_pkg::coord_y_t'(cfg.v_back) - 9'd1;
   end

   // Last cycle of each divide period
   assign tick = (div_cnt >= lcd_video_pkg::clk_div_t'(cfg.clk_div - 8'd1));

   assign hsync = (h_cnt >= h_sync_start) && (h_cnt < h_sync_end);
   // Vsync by whole lines
   assign vsync = (v_cnt >= v_sync_start) && (v_cnt < v_sync_end);
   assign de    = (h_cnt < cfg.h_active) && (v_cnt < cfg.v_active);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         div_cnt      <= '0;
         pixel_strobe <= 1'b0;
         h_cnt        <= '0;
         v_cnt        <= '0;
         beat         <= '0;
      end else if (!cfg.enable) begin
         // Parked at the top left with the beat idle
         div_cnt      <= '0;
         pixel_strobe <= 1'b0;
         h_cnt        <= '0;
         v_cnt        <= '0;
         beat         <= '0;
      end else begin
         pixel_strobe <= tick;
         div_cnt      <= tick ? '0 : lcd_video_pkg::clk_div_t'(div_cnt + 8'd1);
         if (tick) begin
            // Beat and strobe appear together on the next cycle
            beat <= '{hsync: hsync, vsync: vsync, de: de, x: h_cnt, y: v_cnt};
            if (h_cnt >= h_last) begin
               h_cnt <= '0;
               v_cnt <= (v_cnt >= v_last) ? '0 : v_cnt + 9'd1;
            end else begin
               h_cnt <= h_cnt + 10'd1;
            end
         end
      end
   end

endmodule

//--- lcd_pixel_fetch.sv
`timescale 1ns/1ps

module lcd_pixel_fetch (
   input  logic                        clk,
   input  logic                        arst_n,
   input  lcd_video_pkg::fb_write_t    fb_write,
   input  logic                        pixel_strobe,
   input  lcd_video_pkg::timing_beat_t beat,
   output lcd_video_pkg::pixel_beat_t  pixel
);

   lcd_video_pkg::rgb_t     fb_mem [2 ** $bits(lcd_video_pkg::fb_addr_t)];
   lcd_video_pkg::fb_addr_t rd_addr;
   lcd_video_pkg::rgb_t     rd_data;
   logic                    hsync_q;
   logic                    vsync_q;
   logic                    de_q;

   // Write port from outside
   always_ff @(posedge clk) begin
      if (fb_write.enable) begin
         fb_mem[fb_write.address] <= fb_write.data;
      end
   end

   // Tile the 64x32 image from the low bits of y and x
   assign rd_addr = {beat.y[lcd_video_pkg::FB_Y_BITS-1:0],
                     beat.x[lcd_video_pkg::FB_X_BITS-1:0]};

   // Read port returns old data on a colliding write
   always_ff @(posedge clk) begin
      if (pixel_strobe) begin
         rd_data <= fb_mem[rd_addr];
      end
   end

   // Beat moves only with a strobe or on disable
   // Delayed bits line up with rd_data
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hsync_q <= 1'b0;
         vsync_q <= 1'b0;
         de_q    <= 1'b0;
      end else begin
         hsync_q <= beat.hsync;
         vsync_q <= beat.vsync;
         de_q    <= beat.de;
      end
   end

   // Blank outside the active area
   always_comb begin
      pixel.hsync = hsync_q;
      pixel.vsync = vsync_q;
      pixel.de    = de_q;
      pixel.rgb   = de_q ? rd_data : '0;
   end

endmodule

//--- lcd_panel_out.sv
`timescale 1ns/1ps

module lcd_panel_out (
   input  logic                       clk,
   input  logic                       arst_n,
   input  lcd_video_pkg::lcd_cfg_t    cfg,
   input  logic                       pixel_strobe,
   input  lcd_video_pkg::pixel_beat_t pixel,
   output logic                       lcd_clock,
   output logic                       lcd_hsync_n,
   output logic                       lcd_vsync_n,
   output logic                       lcd_display_enable,
   output logic                       lcd_shdn,
   output logic [5:0]                 lcd_red,
   output logic [6:0]                 lcd_green,
   output logic [5:0]                 lcd_blue
);

   lcd_video_pkg::clk_div_t half;
   lcd_video_pkg::clk_div_t phase_cnt;

   // Clock rises half a period after the pins change
   assign half = cfg.clk_div >> 1;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lcd_clock          <= 1'b0;
         lcd_hsync_n        <= 1'b1;
         lcd_vsync_n        <= 1'b1;
         lcd_display_enable <= 1'b0;
         lcd_shdn           <= 1'b0;
         lcd_red            <= '0;
         lcd_green          <= '0;
         lcd_blue           <= '0;
         phase_cnt          <= '0;
      end else begin
         // Backlight pin high means lamp on
         lcd_shdn <= cfg.backlight;
         if (!cfg.enable) begin
            lcd_clock          <= 1'b0;
            lcd_hsync_n        <= 1'b1;
            lcd_vsync_n        <= 1'b1;
            lcd_display_enable <= 1'b0;
            lcd_red            <= '0;
            lcd_green          <= '0;
            lcd_blue           <= '0;
            phase_cnt          <= '0;
         end else if (pixel_strobe) begin
            // Falling edge with new data
            lcd_clock          <= 1'b0;
            phase_cnt          <= 8'd1;
            lcd_hsync_n        <= ~pixel.hsync;
            lcd_vsync_n        <= ~pixel.vsync;
            lcd_display_enable <= pixel.de;
            // Upper bits only, 6/7/6 panel
            lcd_red            <= pixel.rgb.red[7:2];
            lcd_green          <= pixel.rgb.green[7:1];
            lcd_blue           <= pixel.rgb.blue[7:2];
         end else if (phase_cnt >= half) begin
            lcd_clock <= 1'b1;
         end else begin
            phase_cnt <= lcd_video_pkg::clk_div_t'(phase_cnt + 8'd1);
         end
      end
   end

endmodule

//--- lcd_video.sv
`timescale 1ns/1ps

module lcd_video (
   input  logic                     clk,
   input  logic                     arst_n,
   input  lcd_video_pkg::axil_req_t axil_req,
   output lcd_video_pkg::axil_rsp_t axil_rsp,
   input  lcd_video_pkg::fb_write_t fb_write,
   output logic                     lcd_clock,
   output logic                     lcd_hsync_n,
   output logic                     lcd_vsync_n,
   output logic                     lcd_display_enable,
   output logic                     lcd_shdn,
   output logic [5:0]               lcd_red,
   output logic [6:0]               lcd_green,
   output logic [5:0]               lcd_blue
);

   lcd_video_pkg::lcd_cfg_t     cfg;
   logic                        pixel_strobe;
   lcd_video_pkg::timing_beat_t beat;
   lcd_video_pkg::pixel_beat_t  pixel;

   // Host register block
   lcd_csr_axil u_csr (
      .clk      (clk),
      .arst_n   (arst_n),
      .axil_req (axil_req),
      .axil_rsp (axil_rsp),
      .cfg      (cfg)
   );

   // Raster counters and pixel strobe
   lcd_timing u_timing (
      .clk          (clk),
      .arst_n       (arst_n),
      .cfg          (cfg),
      .pixel_strobe (pixel_strobe),
      .beat         (beat)
   );

   lcd_pixel_fetch u_fetch (
      .clk          (clk),
      .arst_n       (arst_n),
      .fb_write     (fb_write),
      .pixel_strobe (pixel_strobe),
      .beat         (beat),
      .pixel        (pixel)
   );

   // Pin stage
   lcd_panel_out u_panel (
      .clk                (clk),
      .arst_n             (arst_n),
      .cfg                (cfg),
      .pixel_strobe       (pixel_strobe),
      .pixel              (pixel),
      .lcd_clock          (lcd_clock),
      .lcd_hsync_n        (lcd_hsync_n),
      .lcd_vsync_n        (lcd_vsync_n),
      .lcd_display_enable (lcd_display_enable),
      .lcd_shdn           (lcd_shdn),
      .lcd_red            (lcd_red),
      .lcd_green          (lcd_green),
      .lcd_blue           (lcd_blue)
   );

endmodule

//--- lcd_video_tb.sv
`timescale 1ns/1ps

module lcd_video_tb;

   // Cycles per frame for the two test geometries at divisor 4
   localparam int SMALL_FRAME    = 15 * 8 * 4;
   localparam int WIDE_FRAME     = 77 * 8 * 4;
   localparam int FB_WORDS       = 2048;
   // Reset, framebuffer fill and frames waited on plus AXI traffic
   localparam int TIMEOUT_CYCLES = 16 + FB_WORDS + 6 * SMALL_FRAME + 5 * WIDE_FRAME + 2000;

   logic                     clk;
   logic                     arst_n;
   lcd_video_pkg::axil_req_t axil_req;
   lcd_video_pkg::axil_rsp_t axil_rsp;
   lcd_video_pkg::fb_write_t fb_write;
   logic                     lcd_clock;
   logic                     lcd_hsync_n;
   logic                     lcd_vsync_n;
   logic                     lcd_display_enable;
   logic                     lcd_shdn;
   logic [5:0]               lcd_red;
   logic [6:0]               lcd_green;
   logic [5:0]               lcd_blue;

   // Copy of the framebuffer contents written to the DUT
   logic [23:0] fb_model [FB_WORDS];
   integer      seed;
   int          errors;
   int          checks;
   int          test_no;
   int          tests_bad;
   int          err_mark;
   int          cycle_cnt;
   logic [1:0]  resp;

   // Monitor state
   logic mon_on;
   logic prev_de;
   logic prev_hs;
   logic prev_vs;
   logic line_open;
   logic frame_open;
   int   mon_x;
   int   mon_y;
   int   max_x;
   int   line_rises;
   int   line_hs;
   int   line_de;
   int   lines_checked;
   int   frame_lines;
   int   frame_de_lines;
   int   frame_vs_lines;
   int   frames_checked;
   int   exp_h_active;
   int   exp_h_total;
   int   exp_h_sync;
   int   exp_v_active;
   int   exp_v_total;
   int   exp_v_sync;

   lcd_video u_dut (
      .clk                (clk),
      .arst_n             (arst_n),
      .axil_req           (axil_req),
      .axil_rsp           (axil_rsp),
      .fb_write           (fb_write),
      .lcd_clock          (lcd_clock),
      .lcd_hsync_n        (lcd_hsync_n),
      .lcd_vsync_n        (lcd_vsync_n),
      .lcd_display_enable (lcd_display_enable),
      .lcd_shdn           (lcd_shdn),
      .lcd_red            (lcd_red),
      .lcd_green          (lcd_green),
      .lcd_blue           (lcd_blue)
   );

   always #4 clk = ~clk;

   // Hard stop
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout, run stopped after %0d cycles", cycle_cnt);
         $display("Testbench failed");
         $finish;
      end
   end

   // Expected 6/7/6 pins with the 64x32 image repeated over the screen
   function automatic logic [18:0] ref_pixel(input int x, input int y);
      logic [23:0] c;
      c = fb_model[(y % 32) * 64 + (x % 64)];
      return {c[23:18], c[15:9], c[7:2]};
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAILED %0t %s expected %0h actual %0h", $time, name, expected, actual);
      end
   endtask

   task automatic report_test(input string name);
      test_no++;
      if (errors == err_mark) begin
         $display("test %0d %s: ok", test_no, name);
      end else begin
         tests_bad++;
         $display("test %0d %s: %0d errors", test_no, name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] wresp);
      int waited;
      waited = 0;
      @(negedge clk);
      // Wait out any pending write response
      while (axil_rsp.b_valid && waited < 20) begin
         @(negedge clk);
         waited++;
      end
      axil_req.aw_valid = 1'b1;
      axil_req.aw_addr  = addr;
      axil_req.w_valid  = 1'b1;
      axil_req.w_data   = data;
      axil_req.w_strb   = strb;
      // Ready seen just before the edge that takes the write
      waited = 0;
      @(posedge clk);
      while (!(axil_rsp.aw_ready || axil_rsp.w_ready) && waited < 20) begin
         @(posedge clk);
         waited++;
      end
      check("aw_ready", 1, axil_rsp.aw_ready);
      check("w_ready", 1, axil_rsp.w_ready);
      @(negedge clk);
      axil_req.aw_valid = 1'b0;
      axil_req.w_valid  = 1'b0;
      waited = 0;
      while (!axil_rsp.b_valid && waited < 20) begin
         @(negedge clk);
         waited++;
      end
      if (!axil_rsp.b_valid) begin
         errors++;
         $display("No write response arrived for address %0h", addr);
      end
      wresp = axil_rsp.b_resp;
      axil_req.b_ready = 1'b1;
      @(negedge clk);
      axil_req.b_ready = 1'b0;
   endtask

   task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] rresp);
      int waited;
      waited = 0;
      @(negedge clk);
      while (!axil_rsp.ar_ready && waited < 20) begin
         @(negedge clk);
         waited++;
      end
      axil_req.ar_valid = 1'b1;
      axil_req.ar_addr  = addr;
      @(negedge clk);
      axil_req.ar_valid = 1'b0;
      waited = 0;
      while (!axil_rsp.r_valid && waited < 20) begin
         @(negedge clk);
         waited++;
      end
      if (!axil_rsp.r_valid) begin
         errors++;
         $display("No read response arrived for address %0h", addr);
      end
      data  = axil_rsp.r_data;
      rresp = axil_rsp.r_resp;
      axil_req.r_ready = 1'b1;
      @(negedge clk);
      axil_req.r_ready = 1'b0;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      logic [1:0] wresp;
      axi_write(addr, data, 4'hF, wresp);
      check("b_resp", lcd_video_pkg::RESP_OKAY, wresp);
   endtask

   task automatic read_expect(input logic [7:0] addr, input logic [31:0] expected,
                              input logic [1:0] expected_resp);
      logic [31:0] data;
      logic [1:0]  rresp;
      axi_read(addr, data, rresp);
      check("r_data", expected, data);
      check("r_resp", expected_resp, rresp);
   endtask

   task automatic fill_framebuffer();
      logic [23:0] word;
      for (int i = 0; i < FB_WORDS; i++) begin
         word = $random(seed);
         fb_model[i] = word;
         @(negedge clk);
         fb_write.enable  = 1'b1;
         fb_write.address = lcd_video_pkg::fb_addr_t'(i);
         fb_write.data    = word;
      end
      @(negedge clk);
      fb_write.enable = 1'b0;
   endtask

   // Porches fixed at front 2, sync 2, back 3 and 1, 1, 2 lines
   task automatic set_geometry(input int h_act);
      write_reg(lcd_video_pkg::REG_H_ACTIVE, h_act);
      write_reg(lcd_video_pkg::REG_H_PORCH, {8'd0, 8'd3, 8'd2, 8'd2});
      write_reg(lcd_video_pkg::REG_V_ACTIVE, 32'd4);
      write_reg(lcd_video_pkg::REG_V_PORCH, {8'd0, 8'd2, 8'd1, 8'd1});
      write_reg(lcd_video_pkg::REG_CLK_DIV, 32'd4);
      exp_h_active = h_act;
      exp_h_total  = h_act + 7;
      exp_h_sync   = 2;
      exp_v_active = 4;
      exp_v_total  = 8;
      exp_v_sync   = 1;
   endtask

   task automatic reset_monitor();
      prev_de        = 1'b0;
      prev_hs        = 1'b1;
      prev_vs        = 1'b1;
      line_open      = 1'b0;
      frame_open     = 1'b0;
      mon_x          = 0;
      mon_y          = 0;
      max_x          = 0;
      line_rises     = 0;
      line_hs        = 0;
      line_de        = 0;
      lines_checked  = 0;
      frame_lines    = 0;
      frame_de_lines = 0;
      frame_vs_lines = 0;
      frames_checked = 0;
   endtask

   // Monitor samples on the rising pixel clock like the panel
   always @(posedge lcd_clock) begin
      if (mon_on) begin
         // Line window runs from one hsync fall to the next
         if (prev_hs && !lcd_hsync_n) begin
            if (line_open) begin
               check("line_clocks", exp_h_total, line_rises);
               check("hsync_low_clocks", exp_h_sync, line_hs);
               if (line_de != 0) begin
                  check("line_de_pixels", exp_h_active, line_de);
                  frame_de_lines++;
               end
               lines_checked++;
            end
            line_open  = 1'b1;
            line_rises = 0;
            line_hs    = 0;
            line_de    = 0;
            frame_lines++;
            if (!lcd_vsync_n) begin
               frame_vs_lines++;
            end
         end
         // Frame window between vsync falls
         if (prev_vs && !lcd_vsync_n) begin
            if (frame_open) begin
               check("frame_lines", exp_v_total, frame_lines);
               check("frame_de_lines", exp_v_active, frame_de_lines);
               check("vsync_low_lines", exp_v_sync, frame_vs_lines);
               frames_checked++;
            end
            frame_open     = 1'b1;
            frame_lines    = 0;
            frame_de_lines = 0;
            frame_vs_lines = 0;
         end
         if (lcd_display_enable) begin
            check("lcd_rgb", ref_pixel(mon_x, mon_y), {lcd_red, lcd_green, lcd_blue});
            if (mon_x > max_x) begin
               max_x = mon_x;
            end
            mon_x++;
            line_de++;
         end else begin
            // Blanked colour
            check("lcd_rgb", 19'd0, {lcd_red, lcd_green, lcd_blue});
            if (prev_de) begin
               mon_y++;
            end
            mon_x = 0;
         end
         // Next active line after vsync is line 0
         if (!lcd_vsync_n) begin
            mon_y = 0;
         end
         line_rises++;
         if (!lcd_hsync_n) begin
            line_hs++;
         end
         prev_de = lcd_display_enable;
         prev_hs = lcd_hsync_n;
         prev_vs = lcd_vsync_n;
      end
   end

   initial begin
      clk       = 1'b0;
      arst_n    = 1'b0;
      axil_req  = '0;
      fb_write  = '0;
      seed      = 72230;
      errors    = 0;
      checks    = 0;
      test_no   = 0;
      tests_bad = 0;
      err_mark  = 0;
      cycle_cnt = 0;
      mon_on    = 1'b0;
      reset_monitor();
      repeat (16) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      // Pins idle and only ar_ready up
      check("lcd_hsync_n", 1, lcd_hsync_n);
      check("lcd_vsync_n", 1, lcd_vsync_n);
      check("lcd_display_enable", 0, lcd_display_enable);
      check("lcd_clock", 0, lcd_clock);
      check("lcd_shdn", 0, lcd_shdn);
      check("lcd_rgb", 0, {lcd_red, lcd_green, lcd_blue});
      check("aw_ready", 0, axil_rsp.aw_ready);
      check("w_ready", 0, axil_rsp.w_ready);
      check("b_valid", 0, axil_rsp.b_valid);
      check("r_valid", 0, axil_rsp.r_valid);
      check("ar_ready", 1, axil_rsp.ar_ready);
      read_expect(lcd_video_pkg::REG_CTRL, 32'd0, lcd_video_pkg::RESP_OKAY);
      read_expect(lcd_video_pkg::REG_CLK_DIV, 32'd5, lcd_video_pkg::RESP_OKAY);
      read_expect(lcd_video_pkg::REG_H_ACTIVE, 32'd480, lcd_video_pkg::RESP_OKAY);
      read_expect(lcd_video_pkg::REG_H_PORCH, {8'd0, 8'd2, 8'd41, 8'd2},
                  lcd_video_pkg::RESP_OKAY);
      read_expect(lcd_video_pkg::REG_V_ACTIVE, 32'd272, lcd_video_pkg::RESP_OKAY);
      read_expect(lcd_video_pkg::REG_V_PORCH, {8'd0, 8'd2, 8'd10, 8'd2},
                  lcd_video_pkg::RESP_OKAY);
      report_test("reset");

      // Low byte only so 480 keeps its upper bits
      axi_write(lcd_video_pkg::REG_H_ACTIVE, 32'h0000_1234, 4'b0001, resp);
      check("b_resp", lcd_video_pkg::RESP_OKAY, resp);
      read_expect(lcd_video_pkg::REG_H_ACTIVE, 32'h0000_0134, lcd_video_pkg::RESP_OKAY);
      // Sync and back bytes only
      axi_write(lcd_video_pkg::REG_H_PORCH, 32'hAABB_CCDD, 4'b0110, resp);
      check("b_resp", lcd_video_pkg::RESP_OKAY, resp);
      read_expect(lcd_video_pkg::REG_H_PORCH, 32'h00BB_CC02, lcd_video_pkg::RESP_OKAY);
      write_reg(lcd_video_pkg::REG_CLK_DIV, 32'd1);
      read_expect(lcd_video_pkg::REG_CLK_DIV, 32'd2, lcd_video_pkg::RESP_OKAY);
      axi_write(8'h18, 32'hFFFF_FFFF, 4'hF, resp);
      check("b_resp", lcd_video_pkg::RESP_SLVERR, resp);
      read_expect(8'h18, 32'd0, lcd_video_pkg::RESP_SLVERR);
      read_expect(lcd_video_pkg::REG_CTRL, 32'd0, lcd_video_pkg::RESP_OKAY);
      report_test("registers");

      fill_framebuffer();
      set_geometry(8);
      reset_monitor();
      mon_on = 1'b1;
      write_reg(lcd_video_pkg::REG_CTRL, 32'd1);
      while (lines_checked < 10) @(negedge clk);
      report_test("line timing");

      while (frames_checked < 2) @(negedge clk);
      report_test("frame timing");

      // Wider than the 64 pixel tile
      mon_on = 1'b0;
      write_reg(lcd_video_pkg::REG_CTRL, 32'd0);
      set_geometry(70);
      reset_monitor();
      mon_on = 1'b1;
      write_reg(lcd_video_pkg::REG_CTRL, 32'd1);
      while (frames_checked < 2) @(negedge clk);
      check("max_x", 69, max_x);
      report_test("pixel data");

      mon_on = 1'b0;
      write_reg(lcd_video_pkg::REG_CTRL, 32'd0);
      repeat (WIDE_FRAME) begin
         @(negedge clk);
         check("lcd_hsync_n", 1, lcd_hsync_n);
         check("lcd_vsync_n", 1, lcd_vsync_n);
         check("lcd_display_enable", 0, lcd_display_enable);
         check("lcd_clock", 0, lcd_clock);
      end
      // Backlight alone with the display still off
      write_reg(lcd_video_pkg::REG_CTRL, 32'd2);
      repeat (2) @(negedge clk);
      check("lcd_shdn", 1, lcd_shdn);
      check("lcd_display_enable", 0, lcd_display_enable);
      write_reg(lcd_video_pkg::REG_CTRL, 32'd0);
      repeat (2) @(negedge clk);
      check("lcd_shdn", 0, lcd_shdn);
      report_test("disable and backlight");

      $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
               test_no, tests_bad, checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- lcd_video.f
lcd_video_pkg.sv
lcd_csr_axil.sv
lcd_timing.sv
lcd_pixel_fetch.sv
lcd_panel_out.sv
lcd_video.sv
lcd_video_tb.sv

//--- Bender.yml
package:
  name: lcd_video

sources:
  - lcd_video_pkg.sv
  - lcd_csr_axil.sv
  - lcd_timing.sv
  - lcd_pixel_fetch.sv
  - lcd_panel_out.sv
  - lcd_video.sv
  - target: simulation
    files:
      - lcd_video_tb.sv
